// ==== rtl/mem_stage_pkg.sv ====
`default_nettype none

package mem_stage_pkg;

  ////////////////////
  // Pipeline data types
  ////////////////////

  // Data word or byte address
  typedef logic [31:0] word_t;

  // Architectural register number
  typedef logic [4:0] reg_idx_t;

  // One lane enable per byte of a word
  typedef logic [3:0] byte_en_t;

  ////////////////////
  // Memory op controls
  ////////////////////

  // One-hot load kind, zero when no load
  typedef logic [4:0] load_ctrl_t;

  localparam load_ctrl_t ld_lb  = 5'b00001;
  localparam load_ctrl_t ld_lh  = 5'b00010;
  localparam load_ctrl_t ld_lw  = 5'b00100;
  localparam load_ctrl_t ld_lbu = 5'b01000;
  localparam load_ctrl_t ld_lhu = 5'b10000;

  // One-hot store kind, zero when no store
  typedef logic [2:0] store_ctrl_t;

  localparam store_ctrl_t st_sb = 3'b001;
  localparam store_ctrl_t st_sh = 3'b010;
  localparam store_ctrl_t st_sw = 3'b100;

endpackage

`default_nettype wire

// ==== rtl/axi_lite_pkg.sv ====
`default_nettype none

package axi_lite_pkg;

  // Byte address on AW and AR
  typedef logic [31:0] axi_addr_t;

  // Data on W and R
  typedef logic [31:0] axi_data_t;

  // One strobe bit per W byte lane
  typedef logic [3:0] axi_strb_t;

  // B and R response code
  typedef logic [1:0] axi_resp_t;

  localparam axi_resp_t resp_okay = 2'b00;

endpackage

`default_nettype wire

// ==== rtl/store_align.sv ====
`timescale 1ns/10ps
`default_nettype none

module store_align (
  input  mem_stage_pkg::store_ctrl_t store_ctrl,
  input  mem_stage_pkg::word_t       alu_result,
  input  mem_stage_pkg::word_t       rs2_data,
  input  mem_stage_pkg::reg_idx_t    rs2,
  input  logic                       memwrite,
  input  logic                       wb_regwrite,
  input  mem_stage_pkg::reg_idx_t    wb_rd,
  input  mem_stage_pkg::word_t       wb_result,
  output mem_stage_pkg::byte_en_t    strb,
  output mem_stage_pkg::word_t       wdata
);

  logic [1:0]              off;
  logic                    fwd;
  mem_stage_pkg::word_t    store_data;
  mem_stage_pkg::byte_en_t base_strb;
  logic [7:0]              strb_dbl;
  logic [63:0]             data_dbl;

  // Byte offset inside the word
  assign off = alu_result[1:0];

  // Instruction ahead writes rs2 so take its result
  assign fwd        = memwrite && wb_regwrite && (wb_rd == rs2);
  assign store_data = fwd ? wb_result : rs2_data;

  // Lane pattern at offset zero
  always_comb begin
    case (store_ctrl)
      mem_stage_pkg::st_sb: base_strb = 4'b0001;
      mem_stage_pkg::st_sh: base_strb = 4'b0011;
      mem_stage_pkg::st_sw: base_strb = 4'b1111;
      default:              base_strb = 4'b0000;
    endcase
  end

  // Rotate strobe left by offset, so sh at 3 wraps to lane 0
  assign strb_dbl = {base_strb, base_strb} << off;
  assign strb     = strb_dbl[7:4];

  // Same rotation for the data, in whole bytes
  assign data_dbl = {store_data, store_data} << {off, 3'b000};
  assign wdata    = data_dbl[63:32];

endmodule

`default_nettype wire

// ==== rtl/access_fsm.sv ====
`timescale 1ns/10ps
`default_nettype none

module access_fsm (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    ex_valid,
  input  logic                    memread,
  input  logic                    memwrite,
  input  mem_stage_pkg::word_t    addr,
  input  mem_stage_pkg::word_t    wdata,
  input  mem_stage_pkg::byte_en_t wstrb,
  input  logic                    awready,
  input  logic                    wready,
  input  logic                    bvalid,
  input  axi_lite_pkg::axi_resp_t bresp,
  input  logic                    arready,
  input  logic                    rvalid,
  input  axi_lite_pkg::axi_data_t rdata,
  input  axi_lite_pkg::axi_resp_t rresp,
  output logic                    awvalid,
  output axi_lite_pkg::axi_addr_t awaddr,
  output logic                    wvalid,
  output axi_lite_pkg::axi_data_t wdata_out,
  output axi_lite_pkg::axi_strb_t wstrb_out,
  output logic                    bready,
  output logic                    arvalid,
  output axi_lite_pkg::axi_addr_t araddr,
  output logic                    rready,
  output logic                    stage_hold,
  output logic                    resp_done,
  output mem_stage_pkg::word_t    rdata_out
);

  typedef enum logic [1:0] {idle, write_addr, read_addr, wait_resp} fsm_state_t;

  fsm_state_t              state;
  fsm_state_t              state_nxt;
  logic                    mem_op;
  logic                    resp_err;
  mem_stage_pkg::word_t    addr_q;
  mem_stage_pkg::word_t    wdata_q;
  mem_stage_pkg::byte_en_t wstrb_q;

  // New load or store waiting in the stage
  assign mem_op = ex_valid && (memread || memwrite);

  ////////////////////
  // State machine
  ////////////////////

  always_comb begin
    state_nxt = state;
    case (state)
      idle: begin
        if (ex_valid && memwrite) begin
          state_nxt = write_addr;
        end else if (ex_valid && memread) begin
          state_nxt = read_addr;
        end
      end
      // AW and W go out together and are accepted together
      write_addr: if (awready && wready) state_nxt = wait_resp;
      read_addr:  if (arready) state_nxt = wait_resp;
      wait_resp:  if (bvalid || rvalid) state_nxt = idle;
      default:    state_nxt = idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= idle;
    end else begin
      state <= state_nxt;
    end
  end

  // Request payload held stable until its transfer
  always_ff @(posedge clk) begin
    if (state == idle && mem_op) begin
      addr_q  <= addr;
      wdata_q <= wdata;
      wstrb_q <= wstrb;
    end
  end

  ////////////////////
  // Channel outputs
  ////////////////////

  assign awvalid   = (state == write_addr);
  assign wvalid    = (state == write_addr);
  assign awaddr    = addr_q;
  assign wdata_out = wdata_q;
  assign wstrb_out = wstrb_q;
  assign arvalid   = (state == read_addr);
  assign araddr    = addr_q;

  // Both response channels ready while waiting
  assign bready = (state == wait_resp);
  assign rready = (state == wait_resp);

  // Response cycle, single outstanding access
  assign resp_done = (state == wait_resp) && (bvalid || rvalid);

  // Failed response hands back a zero word
  assign resp_err  = (bvalid && bresp != axi_lite_pkg::resp_okay) ||
                     (rvalid && rresp != axi_lite_pkg::resp_okay);
  assign rdata_out = resp_err ? '0 : rdata;

  // Hold from the first cycle until the response cycle
  assign stage_hold = ((state == idle) && mem_op) || ((state != idle) && !resp_done);

endmodule

`default_nettype wire

// ==== rtl/latency_timer.sv ====
`timescale 1ns/10ps
`default_nettype none

module latency_timer #(
  parameter int ram_latency = 2
) (
  input  logic clk,
  input  logic reset,
  input  logic start,
  output logic done
);

  localparam int cnt_w = $clog2(ram_latency + 1);

  logic [cnt_w-1:0] cnt;

  // Load on start, then count down to zero
  always_ff @(posedge clk) begin
    if (reset) begin
      cnt <= '0;
    end else if (start) begin
      cnt <= cnt_w'(ram_latency);
    end else if (cnt != '0) begin
      cnt <= cnt - 1'b1;
    end
  end

  // Last count lands ram_latency cycles after start
  assign done = (cnt == cnt_w'(1));

endmodule

`default_nettype wire

// ==== rtl/data_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

module data_ram #(
  parameter int ram_words   = 64,
  parameter int ram_latency = 2
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    awvalid,
  output logic                    awready,
  input  axi_lite_pkg::axi_addr_t awaddr,
  input  logic                    wvalid,
  output logic                    wready,
  input  axi_lite_pkg::axi_data_t wdata,
  input  axi_lite_pkg::axi_strb_t wstrb,
  output logic                    bvalid,
  input  logic                    bready,
  output axi_lite_pkg::axi_resp_t bresp,
  input  logic                    arvalid,
  output logic                    arready,
  input  axi_lite_pkg::axi_addr_t araddr,
  output logic                    rvalid,
  input  logic                    rready,
  output axi_lite_pkg::axi_data_t rdata,
  output axi_lite_pkg::axi_resp_t rresp
);

  localparam int idx_w = $clog2(ram_words);

  typedef enum logic [1:0] {ram_idle, ram_busy, ram_resp} ram_state_t;

  ram_state_t              state;
  axi_lite_pkg::axi_data_t mem [ram_words];
  logic [idx_w-1:0]        idx_q;
  axi_lite_pkg::axi_data_t wdata_q;
  axi_lite_pkg::axi_strb_t wstrb_q;
  logic                    is_write_q;
  logic                    accept_wr;
  logic                    accept_rd;
  logic                    done;
  logic                    resp_valid;
  logic                    resp_taken;

  // Accept only when idle, writes first
  assign awready   = (state == ram_idle);
  assign wready    = (state == ram_idle);
  assign arready   = (state == ram_idle);
  assign accept_wr = (state == ram_idle) && awvalid && wvalid;
  assign accept_rd = (state == ram_idle) && arvalid && !accept_wr;

  // Response pacing
  latency_timer #(
    .ram_latency(ram_latency)
  ) u_timer (
    .clk  (clk),
    .reset(reset),
    .start(accept_wr || accept_rd),
    .done (done)
  );

  // Response shows up on done and stays until taken
  assign resp_valid = ((state == ram_busy) && done) || (state == ram_resp);
  assign bvalid     = resp_valid && is_write_q;
  assign rvalid     = resp_valid && !is_write_q;
  assign resp_taken = is_write_q ? bready : rready;
  assign bresp      = axi_lite_pkg::resp_okay;
  assign rresp      = axi_lite_pkg::resp_okay;

  // Word stays put until the next request
  assign rdata = mem[idx_q];

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ram_idle;
    end else begin
      case (state)
        ram_idle: if (accept_wr || accept_rd) state <= ram_busy;
        ram_busy: if (done) state <= resp_taken ? ram_idle : ram_resp;
        ram_resp: if (resp_taken) state <= ram_idle;
        default:  state <= ram_idle;
      endcase
    end
  end

  // Request latch, address wraps on depth
  always_ff @(posedge clk) begin
    if (accept_wr) begin
      idx_q      <= awaddr[idx_w+1:2];
      wdata_q    <= wdata;
      wstrb_q    <= wstrb;
      is_write_q <= 1'b1;
    end else if (accept_rd) begin
      idx_q      <= araddr[idx_w+1:2];
      is_write_q <= 1'b0;
    end
  end

  // Strobed write when the timer expires
  always_ff @(posedge clk) begin
    if (state == ram_busy && done && is_write_q) begin
      for (int i = 0; i < 4; i++) begin
        if (wstrb_q[i]) mem[idx_q][8*i +: 8] <= wdata_q[8*i +: 8];
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/writeback_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module writeback_stage (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      ex_valid,
  input  logic                      stage_hold,
  input  logic                      resp_done,
  input  mem_stage_pkg::word_t      ex_alu_result,
  input  mem_stage_pkg::reg_idx_t   ex_rd,
  input  logic                      ex_regwrite,
  input  logic                      ex_memread,
  input  mem_stage_pkg::load_ctrl_t ex_load_ctrl,
  input  mem_stage_pkg::word_t      mem_rdata,
  output logic                      wb_valid,
  output logic                      wb_regwrite,
  output mem_stage_pkg::reg_idx_t   wb_rd,
  output mem_stage_pkg::word_t      wb_alu_result,
  output logic                      wb_memread,
  output mem_stage_pkg::word_t      wb_mem_result,
  output mem_stage_pkg::word_t      wb_result
);

  logic                      advance;
  mem_stage_pkg::word_t      rdata_q;
  logic [1:0]                off_q;
  mem_stage_pkg::load_ctrl_t load_ctrl_q;
  logic [63:0]               rdata_dbl;
  mem_stage_pkg::word_t      aligned;

  // Op completes with no hold, or on the memory response
  assign advance = (ex_valid && !stage_hold) || resp_done;

  ////////////////////
  // MEM/WB registers
  ////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_valid    <= 1'b0;
      wb_regwrite <= 1'b0;
      wb_memread  <= 1'b0;
    end else begin
      wb_valid <= advance;
      if (advance) begin
        wb_regwrite <= ex_regwrite;
        wb_memread  <= ex_memread;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      wb_rd         <= ex_rd;
      wb_alu_result <= ex_alu_result;
      rdata_q       <= mem_rdata;
      off_q         <= ex_alu_result[1:0];
      load_ctrl_q   <= ex_load_ctrl;
    end
  end

  ////////////////////
  // Load extension
  ////////////////////

  // Rotate addressed lanes back down to byte 0
  assign rdata_dbl = {rdata_q, rdata_q} >> {off_q, 3'b000};
  assign aligned   = rdata_dbl[31:0];

  always_comb begin
    case (load_ctrl_q)
      mem_stage_pkg::ld_lb:  wb_mem_result = {{24{aligned[7]}}, aligned[7:0]};
      mem_stage_pkg::ld_lh:  wb_mem_result = {{16{aligned[15]}}, aligned[15:0]};
      mem_stage_pkg::ld_lw:  wb_mem_result = aligned;
      mem_stage_pkg::ld_lbu: wb_mem_result = {24'h0, aligned[7:0]};
      mem_stage_pkg::ld_lhu: wb_mem_result = {16'h0, aligned[15:0]};
      default:               wb_mem_result = '0;
    endcase
  end

  // Value written back, also the forwarding source
  assign wb_result = wb_memread ? wb_mem_result : wb_alu_result;

endmodule

`default_nettype wire

// ==== rtl/mem_stage_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_stage_top #(
  parameter int ram_words   = 64,
  parameter int ram_latency = 2
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       ex_valid,
  input  mem_stage_pkg::word_t       ex_alu_result,
  input  mem_stage_pkg::word_t       ex_rs2_data,
  input  mem_stage_pkg::reg_idx_t    ex_rs2,
  input  mem_stage_pkg::reg_idx_t    ex_rd,
  input  logic                       ex_regwrite,
  input  logic                       ex_memread,
  input  logic                       ex_memwrite,
  input  mem_stage_pkg::store_ctrl_t ex_store_ctrl,
  input  mem_stage_pkg::load_ctrl_t  ex_load_ctrl,
  output logic                       stage_hold,
  output logic                       wb_valid,
  output logic                       wb_regwrite,
  output mem_stage_pkg::reg_idx_t    wb_rd,
  output mem_stage_pkg::word_t       wb_alu_result,
  output logic                       wb_memread,
  output mem_stage_pkg::word_t       wb_mem_result
);

  // Store path
  mem_stage_pkg::byte_en_t st_strb;
  mem_stage_pkg::word_t    st_wdata;
  mem_stage_pkg::word_t    wb_result;
  mem_stage_pkg::word_t    mem_rdata;
  logic                    resp_done;

  // AXI4-Lite between FSM and RAM
  logic                    awvalid, awready, wvalid, wready, bvalid, bready;
  logic                    arvalid, arready, rvalid, rready;
  axi_lite_pkg::axi_addr_t awaddr, araddr;
  axi_lite_pkg::axi_data_t wdata, rdata;
  axi_lite_pkg::axi_strb_t wstrb;
  axi_lite_pkg::axi_resp_t bresp, rresp;

  store_align u_store_align (
    .store_ctrl(ex_store_ctrl), .alu_result(ex_alu_result), .rs2_data(ex_rs2_data),
    .rs2(ex_rs2), .memwrite(ex_memwrite), .wb_regwrite(wb_regwrite), .wb_rd(wb_rd),
    .wb_result(wb_result), .strb(st_strb), .wdata(st_wdata)
  );

  access_fsm u_access_fsm (
    .clk(clk), .reset(reset), .ex_valid(ex_valid), .memread(ex_memread),
    .memwrite(ex_memwrite), .addr(ex_alu_result), .wdata(st_wdata), .wstrb(st_strb),
    .awready(awready), .wready(wready), .bvalid(bvalid), .bresp(bresp),
    .arready(arready), .rvalid(rvalid), .rdata(rdata), .rresp(rresp),
    .awvalid(awvalid), .awaddr(awaddr), .wvalid(wvalid), .wdata_out(wdata),
    .wstrb_out(wstrb), .bready(bready), .arvalid(arvalid), .araddr(araddr),
    .rready(rready), .stage_hold(stage_hold), .resp_done(resp_done), .rdata_out(mem_rdata)
  );

  data_ram #(
    .ram_words(ram_words), .ram_latency(ram_latency)
  ) u_data_ram (
    .clk(clk), .reset(reset), .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
    .wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
    .bvalid(bvalid), .bready(bready), .bresp(bresp),
    .arvalid(arvalid), .arready(arready), .araddr(araddr),
    .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp)
  );

  writeback_stage u_writeback (
    .clk(clk), .reset(reset), .ex_valid(ex_valid), .stage_hold(stage_hold),
    .resp_done(resp_done), .ex_alu_result(ex_alu_result), .ex_rd(ex_rd),
    .ex_regwrite(ex_regwrite), .ex_memread(ex_memread), .ex_load_ctrl(ex_load_ctrl),
    .mem_rdata(mem_rdata), .wb_valid(wb_valid), .wb_regwrite(wb_regwrite), .wb_rd(wb_rd),
    .wb_alu_result(wb_alu_result), .wb_memread(wb_memread),
    .wb_mem_result(wb_mem_result), .wb_result(wb_result)
  );

endmodule

`default_nettype wire

// ==== verif/mem_stage_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_stage_tb;

  localparam int ram_words   = 64;
  localparam int ram_latency = 2;
  localparam int clk_period  = 100;
  localparam int max_vec     = 64;

  // Operation kinds in the vector file
  localparam logic [1:0] kind_alu   = 2'd0;
  localparam logic [1:0] kind_store = 2'd1;
  localparam logic [1:0] kind_load  = 2'd2;

  logic                       clk;
  logic                       reset;
  logic                       ex_valid;
  mem_stage_pkg::word_t       ex_alu_result;
  mem_stage_pkg::word_t       ex_rs2_data;
  mem_stage_pkg::reg_idx_t    ex_rs2;
  mem_stage_pkg::reg_idx_t    ex_rd;
  logic                       ex_regwrite;
  logic                       ex_memread;
  logic                       ex_memwrite;
  mem_stage_pkg::store_ctrl_t ex_store_ctrl;
  mem_stage_pkg::load_ctrl_t  ex_load_ctrl;
  logic                       stage_hold;
  logic                       wb_valid;
  logic                       wb_regwrite;
  mem_stage_pkg::reg_idx_t    wb_rd;
  mem_stage_pkg::word_t       wb_alu_result;
  logic                       wb_memread;
  mem_stage_pkg::word_t       wb_mem_result;

  // Vector table with one entry per golden line
  logic [1:0]                 v_kind [max_vec];
  mem_stage_pkg::word_t       v_addr [max_vec];
  mem_stage_pkg::word_t       v_data [max_vec];
  mem_stage_pkg::reg_idx_t    v_rs2  [max_vec];
  mem_stage_pkg::reg_idx_t    v_rd   [max_vec];
  logic                       v_rw   [max_vec];
  mem_stage_pkg::store_ctrl_t v_st   [max_vec];
  mem_stage_pkg::load_ctrl_t  v_ld   [max_vec];
  mem_stage_pkg::word_t       v_exp  [max_vec];
  int                         n_vec;

  // Issued ops waiting for wb_valid with the oldest at the front
  int pend_q [$];
  int mon_idx;
  int cycle_cnt;
  int cycle_limit;

  mem_stage_top #(
    .ram_words  (ram_words),
    .ram_latency(ram_latency)
  ) u_dut (
    .clk(clk), .reset(reset), .ex_valid(ex_valid), .ex_alu_result(ex_alu_result),
    .ex_rs2_data(ex_rs2_data), .ex_rs2(ex_rs2), .ex_rd(ex_rd), .ex_regwrite(ex_regwrite),
    .ex_memread(ex_memread), .ex_memwrite(ex_memwrite), .ex_store_ctrl(ex_store_ctrl),
    .ex_load_ctrl(ex_load_ctrl), .stage_hold(stage_hold), .wb_valid(wb_valid),
    .wb_regwrite(wb_regwrite), .wb_rd(wb_rd), .wb_alu_result(wb_alu_result),
    .wb_memread(wb_memread), .wb_mem_result(wb_mem_result)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  ////////////////////
  // Result checks
  ////////////////////

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check_word(input string what, input mem_stage_pkg::word_t got,
                            input mem_stage_pkg::word_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("[ERROR] %0t ns: %s is %h, expected %h",
                                  $time, what, got, exp));
    end
  endtask

  task automatic check_reg_idx(input string what, input mem_stage_pkg::reg_idx_t got,
                               input mem_stage_pkg::reg_idx_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("[ERROR] %0t ns: %s is %h, expected %h",
                                  $time, what, got, exp));
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("[ERROR] %0t ns: %s is %b, expected %b",
                                  $time, what, got, exp));
    end
  endtask

  ////////////////////
  // Golden vectors
  ////////////////////

  // Comment lines fail the hex scan and are skipped
  task automatic load_vectors();
    int                fd;
    int                rc;
    logic [8*128-1:0]  line_buf;
    logic [31:0]       f_kind, f_addr, f_data, f_rs2, f_rd, f_rw, f_st, f_ld, f_exp;
    n_vec = 0;
    fd = $fopen("verif/mem_stage_golden.txt", "r");
    if (fd == 0) begin
      stop_with_failure("Could not open the golden vector file verif/mem_stage_golden.txt");
    end
    while (!$feof(fd) && n_vec < max_vec) begin
      line_buf = '0;
      rc = $fgets(line_buf, fd);
      if (rc > 0) begin
        rc = $sscanf(line_buf, "%h %h %h %h %h %h %h %h %h", f_kind, f_addr, f_data,
                     f_rs2, f_rd, f_rw, f_st, f_ld, f_exp);
        if (rc == 9) begin
          v_kind[n_vec] = f_kind[1:0];
          v_addr[n_vec] = f_addr;
          v_data[n_vec] = f_data;
          v_rs2[n_vec]  = f_rs2[4:0];
          v_rd[n_vec]   = f_rd[4:0];
          v_rw[n_vec]   = f_rw[0];
          v_st[n_vec]   = f_st[2:0];
          v_ld[n_vec]   = f_ld[4:0];
          v_exp[n_vec]  = f_exp;
          n_vec++;
        end
      end
    end
    $fclose(fd);
    if (n_vec == 0) begin
      stop_with_failure("The golden vector file holds no operations");
    end
  endtask

  ////////////////////
  // Upstream driver
  ////////////////////

  // Starts on a falling edge and returns on the falling edge after acceptance
  task automatic issue_op(input int i);
    logic hold_now;
    logic hold_seen;
    hold_now  = 1'b1;
    hold_seen = 1'b0;
    ex_valid      = 1'b1;
    ex_alu_result = v_addr[i];
    ex_rs2_data   = v_data[i];
    ex_rs2        = v_rs2[i];
    ex_rd         = v_rd[i];
    ex_regwrite   = v_rw[i];
    ex_memwrite   = (v_kind[i] == kind_store);
    ex_memread    = (v_kind[i] == kind_load);
    ex_store_ctrl = v_st[i];
    ex_load_ctrl  = v_ld[i];
    pend_q.push_back(i);
    // Sample hold a quarter period after the drive and well before the rising edge
    while (hold_now) begin
      #(clk_period / 4);
      hold_now = stage_hold;
      if (hold_now) hold_seen = 1'b1;
      @(negedge clk);
    end
    if (v_kind[i] == kind_alu) begin
      check_bit("stage_hold for ALU op", hold_seen, 1'b0);
      check_bit("wb_valid one cycle after ALU op", wb_valid, 1'b1);
    end else begin
      check_bit("stage_hold for memory op", hold_seen, 1'b1);
    end
  endtask

  ////////////////////
  // Write-back monitor
  ////////////////////

  // Each wb_valid retires the oldest issued op
  always @(negedge clk) begin
    if (wb_valid) begin
      if (pend_q.size() == 0) begin
        stop_with_failure("wb_valid was raised with no operation outstanding");
      end else begin
        mon_idx = pend_q.pop_front();
        if (v_kind[mon_idx] == kind_load) begin
          check_word("wb_mem_result", wb_mem_result, v_exp[mon_idx]);
        end else begin
          check_word("wb_alu_result", wb_alu_result, v_exp[mon_idx]);
        end
        check_reg_idx("wb_rd", wb_rd, v_rd[mon_idx]);
        check_bit("wb_regwrite", wb_regwrite, v_rw[mon_idx]);
        check_bit("wb_memread", wb_memread, v_kind[mon_idx] == kind_load);
      end
    end
  end

  // Watchdog with a limit set once the vectors are known
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
      stop_with_failure($sformatf("Timeout: the run did not finish within %0d cycles",
                                  cycle_limit));
    end
  end

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    reset         = 1'b1;
    ex_valid      = 1'b0;
    ex_alu_result = '0;
    ex_rs2_data   = '0;
    ex_rs2        = '0;
    ex_rd         = '0;
    ex_regwrite   = 1'b0;
    ex_memread    = 1'b0;
    ex_memwrite   = 1'b0;
    ex_store_ctrl = '0;
    ex_load_ctrl  = '0;
    cycle_cnt     = 0;
    cycle_limit   = 0;
    load_vectors();
    cycle_limit = n_vec * (ram_latency + 4) + 20;
    repeat (3) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    // Quiet pipeline before any op
    check_bit("wb_valid after reset", wb_valid, 1'b0);
    check_bit("stage_hold after reset", stage_hold, 1'b0);
    for (int i = 0; i < n_vec; i++) begin
      issue_op(i);
    end
    ex_valid = 1'b0;
    while (pend_q.size() != 0) begin
      @(negedge clk);
    end
    // A couple of idle cycles to catch a stray wb_valid
    repeat (2) @(negedge clk);
    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/mem_stage_golden.txt ====
# kind addr_or_result rs2_data rs2 rd regwrite store_ctrl load_ctrl expected, all hex
# kind 0 alu, 1 store, 2 load; expected is the loaded value, else the ALU result
0 0000abcd 00000000 00 05 1 0 00 0000abcd
1 00000040 8899aabb 06 00 0 4 00 00000040
2 00000040 00000000 00 07 1 0 01 ffffffbb
2 00000041 00000000 00 08 1 0 01 ffffffaa
2 00000042 00000000 00 09 1 0 08 00000099
2 00000043 00000000 00 0a 1 0 08 00000088
2 00000040 00000000 00 0b 1 0 02 ffffaabb
2 00000042 00000000 00 0c 1 0 10 00008899
2 00000042 00000000 00 0d 1 0 02 ffff8899
2 00000040 00000000 00 0e 1 0 04 8899aabb
2 00000043 00000000 00 0f 1 0 10 0000bb88
1 00000044 11223344 01 00 0 4 00 00000044
1 00000044 000000a0 02 00 0 1 00 00000044
1 00000045 000000b1 02 00 0 1 00 00000045
1 00000046 000000c2 02 00 0 1 00 00000046
1 00000047 000000d3 02 00 0 1 00 00000047
2 00000044 00000000 00 10 1 0 04 d3c2b1a0
1 00000048 55667788 01 00 0 4 00 00000048
1 00000048 0000e0e1 02 00 0 2 00 00000048
1 00000049 0000f1f2 02 00 0 2 00 00000049
1 0000004a 00001234 02 00 0 2 00 0000004a
1 0000004b 0000abcd 02 00 0 2 00 0000004b
2 00000048 00000000 00 11 1 0 04 cd34f2ab
2 00000040 00000000 00 12 1 0 04 8899aabb
1 0000004c deadbeef 12 00 0 4 00 0000004c
2 0000004c 00000000 00 13 1 0 04 8899aabb
0 0000cafe 00000000 00 14 1 0 00 0000cafe
1 00000050 00000000 14 00 0 4 00 00000050
2 00000050 00000000 00 15 1 0 04 0000cafe
0 12345678 00000000 00 1f 1 0 00 12345678

// ==== sim.f ====
rtl/mem_stage_pkg.sv
rtl/axi_lite_pkg.sv
rtl/store_align.sv
rtl/access_fsm.sv
rtl/latency_timer.sv
rtl/data_ram.sv
rtl/writeback_stage.sv
rtl/mem_stage_top.sv
verif/mem_stage_tb.sv

// ==== Makefile ====
SIM := obj_dir/Vmem_stage_tb

.PHONY: all run clean

all: run

$(SIM): sim.f $(wildcard rtl/*.sv) $(wildcard verif/*.sv)
	verilator --binary --timing --timescale 1ns/10ps -Wno-fatal \
		-f sim.f --top-module mem_stage_tb

run: $(SIM)
	$(SIM) | tee sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log
